/* Bender.yml */
package:
  name: noc_merge

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/noc_merge_pkg.sv
      - verilog/noc_flit_fifo.sv
      - verilog/noc_packet_arbiter.sv
      - verilog/noc_merge_top.sv

  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/noc_merge_clkgen.sv
      - sim/noc_merge_chk.sv
      - sim/noc_merge_tb.sv

/* filelist.f */
+incdir+verilog
verilog/noc_merge_pkg.sv
verilog/noc_flit_fifo.sv
verilog/noc_packet_arbiter.sv
verilog/noc_merge_top.sv
sim/noc_merge_clkgen.sv
sim/noc_merge_chk.sv
sim/noc_merge_tb.sv

/* sim/noc_merge_chk.sv */
`timescale 1ns/10ps

module noc_merge_chk (
  input logic       clk,
  input logic       i_arst_n,
  input logic       i_clear,
  input logic [1:0] i_pop,
  input logic       i_valid,
  input logic       i_ready,
  input logic       i_port,
  input logic       i_lock_active
);

  int unsigned fail_count = 0;

  a_one_pop: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_pop[0] && i_pop[1]))
    else begin
      fail_count = fail_count + 1;
      $error("Both FIFOs were popped in the same cycle");
    end

  // A waiting flit stays offered until the link takes it
  a_valid_held: assert property (@(posedge clk) disable iff (!i_arst_n || i_clear)
    (i_valid && !i_ready && !i_clear) |=> i_valid)
    else begin
      fail_count = fail_count + 1;
      $error("Output valid dropped before the flit was accepted");
    end

  // The port that sent the packet head keeps the link until the packet closes
  a_lock_port: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_lock_active |-> (i_port == $past(i_port)))
    else begin
      fail_count = fail_count + 1;
      $error("Output switched ports inside an open packet");
    end

endmodule

bind noc_packet_arbiter noc_merge_chk chk_i (
  .clk           (clk        ),
  .i_arst_n      (i_arst_n   ),
  .i_clear       (i_clear    ),
  .i_pop         (o_pop      ),
  .i_valid       (o_valid    ),
  .i_ready       (i_ready    ),
  .i_port        (o_port     ),
  .i_lock_active (lock_active)
);

/* sim/noc_merge_clkgen.sv */
`timescale 1ns/10ps

module noc_merge_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
)(
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;  // Released away from the rising edge
  end

endmodule

/* sim/noc_merge_tb.sv */
`timescale 1ns/10ps
`include "noc_merge_config.svh"

module noc_merge_tb
  import noc_merge_pkg::*;
();

  localparam int DEPTH    = `NOC_FIFO_DEPTH;
  localparam int OP_PUSH  = 0;
  localparam int OP_CLEAR = 1;
  localparam int OP_DRAIN = 2;
  localparam int OUT_LOW  = 0;
  localparam int OUT_HIGH = 1;
  localparam int OUT_RAND = 2;
  localparam int NO_CHECK = -1;

  logic           clk;
  logic           arst_n;
  logic           i_clear;
  logic           i_in0_valid;
  logic           o_in0_ready;
  noc_flit_kind_e i_in0_kind;
  noc_flit_data_u i_in0_data;
  logic           i_in1_valid;
  logic           o_in1_ready;
  noc_flit_kind_e i_in1_kind;
  noc_flit_data_u i_in1_data;
  logic           o_in0_almost_full;
  logic           o_in1_almost_full;
  logic           o_out_valid;
  logic           i_out_ready;
  noc_flit_kind_e o_out_kind;
  noc_flit_data_u o_out_data;
  logic           o_out_port;

  // Expected status in the table is {out_valid, almost_full, ready} of the row's port
  string          row_name [$];
  int             row_op   [$];
  int             row_port [$];
  noc_flit_kind_e row_kind [$];
  logic [31:0]    row_data [$];
  logic           row_urg  [$];
  int             row_mode [$];
  int             row_exp  [$];

  logic [33:0] q0 [$];  // Model FIFO entries are {kind, data}
  logic [33:0] q1 [$];
  logic        m_lock;
  logic        m_lock_port;
  logic        m_rr;

  string cur_test    = "reset";
  int    out_mode    = OUT_LOW;
  int    seed        = 32'hbfed_0e3c;
  int    errors      = 0;
  int    checks      = 0;
  int    cycles      = 0;
  int    cycle_limit = 0;
  int    assert_fails;

  noc_merge_clkgen u_clkgen (
    .o_clk    (clk   ),
    .o_arst_n (arst_n)
  );

  noc_merge_top dut_i (
    .clk               (clk              ),
    .i_arst_n          (arst_n           ),
    .i_clear           (i_clear          ),
    .i_in0_valid       (i_in0_valid      ),
    .o_in0_ready       (o_in0_ready      ),
    .i_in0_kind        (i_in0_kind       ),
    .i_in0_data        (i_in0_data       ),
    .i_in1_valid       (i_in1_valid      ),
    .o_in1_ready       (o_in1_ready      ),
    .i_in1_kind        (i_in1_kind       ),
    .i_in1_data        (i_in1_data       ),
    .o_in0_almost_full (o_in0_almost_full),
    .o_in1_almost_full (o_in1_almost_full),
    .o_out_valid       (o_out_valid      ),
    .i_out_ready       (i_out_ready      ),
    .o_out_kind        (o_out_kind       ),
    .o_out_data        (o_out_data       ),
    .o_out_port        (o_out_port       )
  );

  task automatic compare(input string what, input logic [33:0] expected,
                         input logic [33:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input int op, input int port,
                         input noc_flit_kind_e kind, input logic [31:0] data,
                         input logic urg, input int mode, input int exp);
    row_name.push_back(name);
    row_op.push_back(op);
    row_port.push_back(port);
    row_kind.push_back(kind);
    row_data.push_back(data);
    row_urg.push_back(urg);
    row_mode.push_back(mode);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    add_row("single_stream", OP_PUSH, 0, HEAD, 32'h0a01_0001, 0, OUT_HIGH, NO_CHECK);
    add_row("single_stream", OP_PUSH, 0, BODY, 32'h1111_0001, 0, OUT_HIGH, NO_CHECK);
    add_row("single_stream", OP_PUSH, 0, BODY, 32'h1111_0002, 0, OUT_HIGH, NO_CHECK);
    add_row("single_stream", OP_PUSH, 0, TAIL, 32'h1111_0003, 0, OUT_HIGH, NO_CHECK);
    add_row("single_stream", OP_PUSH, 1, SINGLE, 32'h0b02_0002, 0, OUT_HIGH, NO_CHECK);
    add_row("single_stream", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    for (int k = 1; k <= DEPTH; k++) begin
      add_row("fill_port0", OP_PUSH, 0, (k == 1) ? HEAD : ((k == DEPTH) ? TAIL : BODY),
              32'h2000_0000 + k, 0, OUT_LOW,
              (k < DEPTH - 1) ? 3'b101 : ((k == DEPTH - 1) ? 3'b111 : 3'b110));
    end
    add_row("fill_port0", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    add_row("packet_lock", OP_PUSH, 0, HEAD, 32'h0c03_0003, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 1, HEAD, 32'h0d04_0004, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 0, BODY, 32'h3333_0001, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 1, BODY, 32'h4444_0001, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 0, TAIL, 32'h3333_0002, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 1, TAIL, 32'h4444_0002, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 0, HEAD, 32'h0c03_0005, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 0, TAIL, 32'h3333_0003, 0, OUT_LOW, NO_CHECK);
    add_row("packet_lock", OP_PUSH, 1, SINGLE, 32'h0d04_0006, 0, OUT_LOW, 3'b101);
    add_row("packet_lock", OP_DRAIN, 1, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    add_row("urgent_head", OP_PUSH, 0, SINGLE, 32'h0e05_0007, 0, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_PUSH, 1, SINGLE, 32'h0f06_0008, 1, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    add_row("urgent_head", OP_PUSH, 1, HEAD, 32'h0f06_0009, 0, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_PUSH, 1, TAIL, 32'h6666_0001, 0, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_PUSH, 0, HEAD, 32'h0e05_000a, 1, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_PUSH, 0, TAIL, 32'h5555_0001, 0, OUT_LOW, NO_CHECK);
    add_row("urgent_head", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    add_row("clear_port0", OP_PUSH, 0, HEAD, 32'h0a07_000b, 0, OUT_LOW, NO_CHECK);
    add_row("clear_port0", OP_PUSH, 0, BODY, 32'h7777_0001, 0, OUT_LOW, NO_CHECK);
    add_row("clear_port0", OP_PUSH, 0, BODY, 32'h7777_0002, 0, OUT_LOW, 3'b101);
    add_row("clear_port0", OP_CLEAR, 0, BODY, 32'h0, 0, OUT_LOW, 3'b001);
    add_row("clear_port0", OP_PUSH, 0, SINGLE, 32'h0a07_000c, 0, OUT_LOW, 3'b101);
    add_row("clear_port0", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_HIGH, 3'b001);
    add_row("random_stream", OP_PUSH, 0, HEAD, 32'h0108_0010, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, SINGLE, 32'h0209_0011, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 0, BODY, 32'h8888_0001, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, HEAD, 32'h0209_0012, 1, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 0, TAIL, 32'h8888_0002, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, BODY, 32'h9999_0001, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, TAIL, 32'h9999_0002, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 0, SINGLE, 32'h0108_0013, 1, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, HEAD, 32'h0209_0014, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_PUSH, 1, TAIL, 32'h9999_0003, 0, OUT_RAND, NO_CHECK);
    add_row("random_stream", OP_DRAIN, 0, BODY, 32'h0, 0, OUT_RAND, 3'b001);
  endtask

  task automatic drive_out_ready();
    int rnd;
    case (out_mode)
      OUT_HIGH: i_out_ready = 1'b1;
      OUT_RAND: begin
        rnd = $random(seed);
        i_out_ready = rnd[0];
      end
      default:  i_out_ready = 1'b0;
    endcase
  endtask

  // Holds the flit on its port until the FIFO takes it
  task automatic push_flit(input int port, input noc_flit_kind_e kind, input logic [31:0] word);
    logic accepted;
    accepted = 1'b0;
    @(negedge clk);
    drive_out_ready();
    if (port == 0) begin
      i_in0_valid = 1'b1;
      i_in0_kind  = kind;
      i_in0_data  = word;
    end else begin
      i_in1_valid = 1'b1;
      i_in1_kind  = kind;
      i_in1_data  = word;
    end
    while (!accepted) begin
      @(posedge clk);
      accepted = (port == 0) ? o_in0_ready : o_in1_ready;
      @(negedge clk);
      drive_out_ready();
    end
    i_in0_valid = 1'b0;
    i_in1_valid = 1'b0;
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    drive_out_ready();
    i_clear = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
    drive_out_ready();
  endtask

  task automatic drain_queues();
    @(negedge clk);
    drive_out_ready();
    while (q0.size() != 0 || q1.size() != 0) begin
      @(negedge clk);
      drive_out_ready();
    end
  endtask

  task automatic check_status(input int port, input int exp);
    @(posedge clk);
    if (port == 0) compare("status", exp, {o_out_valid, o_in0_almost_full, o_in0_ready});
    else compare("status", exp, {o_out_valid, o_in1_almost_full, o_in1_ready});
  endtask

  function automatic logic opens_urgent(input logic [33:0] entry);
    noc_flit_kind_e kind;
    kind = noc_flit_kind_e'(entry[33:32]);
    return ((kind == HEAD) || (kind == SINGLE)) && entry[31];  // Urgent is the header MSB
  endfunction

  // Reference model of both FIFOs and the arbiter that steps on each rising edge
  always @(posedge clk) begin : model
    logic        req0, req1, urg0, urg1;
    logic        exp_port, exp_valid, pop0, pop1, rdy0, rdy1;
    logic [33:0] entry;
    if (!arst_n || i_clear) begin
      q0.delete();
      q1.delete();
      m_lock = 1'b0;
      if (!arst_n) begin
        m_lock_port = 1'b0;
        m_rr        = 1'b0;
      end
    end else begin
      req0 = (q0.size() != 0);
      req1 = (q1.size() != 0);
      urg0 = req0 && opens_urgent(q0[0]);
      urg1 = req1 && opens_urgent(q1[0]);
      if (m_lock) exp_port = m_lock_port;
      else if (urg0 || urg1) exp_port = (m_rr ? urg1 : urg0) ? m_rr : !m_rr;
      else exp_port = (m_rr ? req1 : req0) ? m_rr : !m_rr;
      exp_valid = exp_port ? req1 : req0;
      pop0 = exp_valid && i_out_ready && !exp_port;
      pop1 = exp_valid && i_out_ready && exp_port;
      rdy0 = (q0.size() < DEPTH) || pop0;
      rdy1 = (q1.size() < DEPTH) || pop1;
      compare("out_valid", exp_valid, o_out_valid);
      compare("in0_ready", rdy0, o_in0_ready);
      compare("in1_ready", rdy1, o_in1_ready);
      compare("in0_almost_full", q0.size() >= DEPTH - 1, o_in0_almost_full);
      compare("in1_almost_full", q1.size() >= DEPTH - 1, o_in1_almost_full);
      if (pop0 || pop1) begin
        if (pop1) entry = q1.pop_front();
        else entry = q0.pop_front();
        compare("out_kind", entry[33:32], o_out_kind);
        compare("out_data", entry[31:0], o_out_data);
        compare("out_port", exp_port, o_out_port);
        if (entry[33:32] == HEAD) begin
          m_lock      = 1'b1;
          m_lock_port = exp_port;
        end else if (entry[33:32] != BODY) begin
          m_lock = 1'b0;
          m_rr   = !exp_port;  // Priority passes on at the end of a packet
        end
      end
      if (i_in0_valid && rdy0) q0.push_back({i_in0_kind, i_in0_data});
      if (i_in1_valid && rdy1) q1.push_back({i_in1_kind, i_in1_data});
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run was still busy after %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [31:0] word;
    i_clear     = 1'b0;
    i_in0_valid = 1'b0;
    i_in0_kind  = HEAD;
    i_in0_data  = '0;
    i_in1_valid = 1'b0;
    i_in1_kind  = HEAD;
    i_in1_data  = '0;
    i_out_ready = 1'b0;
    build_table();
    cycle_limit = row_name.size() * DEPTH * 4 + 500;
    @(posedge arst_n);
    @(posedge clk);
    compare("reset_status", 5'b01100,
            {o_out_valid, o_in0_ready, o_in1_ready, o_in0_almost_full, o_in1_almost_full});
    for (int r = 0; r < row_name.size(); r++) begin
      cur_test = row_name[r];
      out_mode = row_mode[r];
      word = row_data[r];
      if (row_kind[r] == HEAD || row_kind[r] == SINGLE) word[31] = row_urg[r];
      case (row_op[r])
        OP_PUSH:  push_flit(row_port[r], row_kind[r], word);
        OP_CLEAR: pulse_clear();
        default:  drain_queues();
      endcase
      if (row_exp[r] != NO_CHECK) check_status(row_port[r], row_exp[r]);
    end
    out_mode = OUT_LOW;
    repeat (4) @(negedge clk);
    assert_fails = dut_i.u_arbiter.chk_i.fail_count;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog/noc_flit_fifo.sv */
`timescale 1ns/10ps
`include "noc_merge_config.svh"

module noc_flit_fifo
  import noc_merge_pkg::*;
#(
  parameter int DEPTH     = `NOC_FIFO_DEPTH,
  parameter int THRESHOLD = DEPTH - 1
)(
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic           i_valid,
  output logic           o_ready,
  input  noc_flit_kind_e i_kind,
  input  noc_flit_data_u i_data,
  output logic           o_head_valid,
  output noc_flit_kind_e o_head_kind,
  output noc_flit_data_u o_head_data,
  input  logic           i_pop,
  output logic           o_almost_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  noc_flit_kind_e kind_mem [DEPTH];
  noc_flit_data_u data_mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          empty;
  logic          full;
  logic          push;
  logic          pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  // A full FIFO still takes a flit when its head leaves in the same cycle
  assign o_ready = ~full | i_pop;

  assign push = i_valid & o_ready;
  assign pop  = i_pop & ~empty;

  assign o_head_valid  = ~empty;
  assign o_head_kind   = kind_mem[rd_ptr];
  assign o_head_data   = data_mem[rd_ptr];
  assign o_almost_full = (count >= CW'(THRESHOLD));

  always_ff @(posedge clk) begin
    if (push) begin
      kind_mem[wr_ptr] <= i_kind;
      data_mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;  // Queued flits are dropped
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/noc_merge_config.svh */
`ifndef NOC_MERGE_CONFIG_SVH
`define NOC_MERGE_CONFIG_SVH

// Width of one flit data word
`define NOC_FLIT_DATA_WIDTH 32

// Entries in each input port FIFO
`define NOC_FIFO_DEPTH 8

`endif

/* verilog/noc_merge_pkg.sv */
`include "noc_merge_config.svh"

package noc_merge_pkg;

  typedef enum logic [1:0] {
    HEAD   = 2'b00,  // Opens a packet
    BODY   = 2'b01,
    TAIL   = 2'b10,  // Closes a packet
    SINGLE = 2'b11   // Head and tail in one flit
  } noc_flit_kind_e;

  // The same word is read as a header on HEAD and SINGLE flits and as raw data otherwise
  typedef union packed {
    struct packed {
      logic        urgent;
      logic [6:0]  dest_id;
      logic [7:0]  src_id;
      logic [15:0] tag;
    } header;
    logic [`NOC_FLIT_DATA_WIDTH-1:0] payload;
  } noc_flit_data_u;

endpackage

/* verilog/noc_merge_top.sv */
`timescale 1ns/10ps
`include "noc_merge_config.svh"

module noc_merge_top
  import noc_merge_pkg::*;
#(
  parameter int FIFO_DEPTH = `NOC_FIFO_DEPTH
)(
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic           i_in0_valid,
  output logic           o_in0_ready,
  input  noc_flit_kind_e i_in0_kind,
  input  noc_flit_data_u i_in0_data,
  input  logic           i_in1_valid,
  output logic           o_in1_ready,
  input  noc_flit_kind_e i_in1_kind,
  input  noc_flit_data_u i_in1_data,
  output logic           o_in0_almost_full,
  output logic           o_in1_almost_full,
  output logic           o_out_valid,
  input  logic           i_out_ready,
  output noc_flit_kind_e o_out_kind,
  output noc_flit_data_u o_out_data,
  output logic           o_out_port
);

  logic [1:0]     head_valid;
  noc_flit_kind_e head_kind0;
  noc_flit_kind_e head_kind1;
  noc_flit_data_u head_data0;
  noc_flit_data_u head_data1;
  logic [1:0]     pop;

  noc_flit_fifo #(
    .DEPTH  (FIFO_DEPTH)
  ) u_fifo0 (
    .clk            (clk               ),
    .i_arst_n       (i_arst_n          ),
    .i_clear        (i_clear           ),
    .i_valid        (i_in0_valid       ),
    .o_ready        (o_in0_ready       ),
    .i_kind         (i_in0_kind        ),
    .i_data         (i_in0_data        ),
    .o_head_valid   (head_valid[0]     ),
    .o_head_kind    (head_kind0        ),
    .o_head_data    (head_data0        ),
    .i_pop          (pop[0]            ),
    .o_almost_full  (o_in0_almost_full )
  );

  noc_flit_fifo #(
    .DEPTH  (FIFO_DEPTH)
  ) u_fifo1 (
    .clk            (clk               ),
    .i_arst_n       (i_arst_n          ),
    .i_clear        (i_clear           ),
    .i_valid        (i_in1_valid       ),
    .o_ready        (o_in1_ready       ),
    .i_kind         (i_in1_kind        ),
    .i_data         (i_in1_data        ),
    .o_head_valid   (head_valid[1]     ),
    .o_head_kind    (head_kind1        ),
    .o_head_data    (head_data1        ),
    .i_pop          (pop[1]            ),
    .o_almost_full  (o_in1_almost_full )
  );

  noc_packet_arbiter u_arbiter (
    .clk      (clk         ),
    .i_arst_n (i_arst_n    ),
    .i_clear  (i_clear     ),
    .i_req    (head_valid  ),
    .i_kind0  (head_kind0  ),
    .i_kind1  (head_kind1  ),
    .i_data0  (head_data0  ),
    .i_data1  (head_data1  ),
    .o_pop    (pop         ),
    .o_valid  (o_out_valid ),
    .o_kind   (o_out_kind  ),
    .o_data   (o_out_data  ),
    .o_port   (o_out_port  ),
    .i_ready  (i_out_ready )
  );

endmodule

/* verilog/noc_packet_arbiter.sv */
`timescale 1ns/10ps

module noc_packet_arbiter
  import noc_merge_pkg::*;
(
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic [1:0]     i_req,
  input  noc_flit_kind_e i_kind0,
  input  noc_flit_kind_e i_kind1,
  input  noc_flit_data_u i_data0,
  input  noc_flit_data_u i_data1,
  output logic [1:0]     o_pop,
  output logic           o_valid,
  output noc_flit_kind_e o_kind,
  output noc_flit_data_u o_data,
  output logic           o_port,
  input  logic           i_ready
);

  logic [1:0] urgent;
  logic       lock_active;
  logic       lock_port;
  logic       rr_prio;
  logic       grant_port;
  logic       transfer;

  // Only a packet opener carries a header with the urgent bit
  function automatic logic is_urgent(input noc_flit_kind_e kind, input noc_flit_data_u data);
    logic opener;
    opener = (kind == HEAD) || (kind == SINGLE);
    return opener && data.header.urgent;
  endfunction

  assign urgent[0] = i_req[0] & is_urgent(i_kind0, i_data0);
  assign urgent[1] = i_req[1] & is_urgent(i_kind1, i_data1);

  always_comb begin
    grant_port = rr_prio;
    if (lock_active) begin
      grant_port = lock_port;  // An open packet keeps the link
    end else if (|urgent) begin
      grant_port = urgent[rr_prio] ? rr_prio : ~rr_prio;
    end else if (|i_req) begin
      grant_port = i_req[rr_prio] ? rr_prio : ~rr_prio;
    end
  end

  assign o_valid  = i_req[grant_port];
  assign o_kind   = grant_port ? i_kind1 : i_kind0;
  assign o_data   = grant_port ? i_data1 : i_data0;
  assign o_port   = grant_port;
  assign transfer = o_valid & i_ready;

  assign o_pop[0] = transfer & ~grant_port;
  assign o_pop[1] = transfer & grant_port;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lock_active <= 1'b0;
      lock_port   <= 1'b0;
      rr_prio     <= 1'b0;
    end else if (i_clear) begin
      lock_active <= 1'b0;
    end else if (transfer) begin
      case (o_kind)
        HEAD: begin
          lock_active <= 1'b1;
          lock_port   <= grant_port;
        end
        TAIL, SINGLE: begin
          lock_active <= 1'b0;
          rr_prio     <= ~grant_port;  // Next packet starts from the other port
        end
        default: begin
          lock_active <= lock_active;
        end
      endcase
    end
  end

endmodule
